// File: logic/asg_config.svh
//////////////////////////////
// widths, table depth and register map of the waveform generator
// included by the package and by every RTL file that needs a width
//////////////////////////////
`ifndef ASG_CONFIG_SVH
`define ASG_CONFIG_SVH

`define ASG_AW        10  // table address width, 1024 entries
`define ASG_CWF       16  // pointer fraction bits
`define ASG_DW        14  // sample width
`define ASG_EW        5   // external event width
`define ASG_GAIN_FRAC 13  // 0x2000 is unity gain
`define ASG_BAW       7   // register address width

// register map, byte offsets
`define ASG_R_CTL 7'h00  // bit0 rst, bit1 start, bit2 stop, bit3 trigger
`define ASG_R_STR 7'h04  // start event mask
`define ASG_R_STP 7'h08  // stop event mask
`define ASG_R_TRG 7'h0c  // trigger event mask
`define ASG_R_IEN 7'h10  // interrupt enable
`define ASG_R_IST 7'h14  // interrupt status, write one to clear
`define ASG_R_SIZ 7'h18  // table size, fixed point
`define ASG_R_OFF 7'h1c  // start offset (phase)
`define ASG_R_STE 7'h20  // step (frequency)
`define ASG_R_BCF 7'h24  // bit0 burst enable, bit1 infinite
`define ASG_R_BDL 7'h28  // burst data length
`define ASG_R_BLN 7'h2c  // burst pause length
`define ASG_R_BNM 7'h30  // burst count
`define ASG_R_SBL 7'h34  // status, phase cycle counter
`define ASG_R_SBN 7'h38  // status, completed bursts
`define ASG_R_MUL 7'h3c  // gain
`define ASG_R_SUM 7'h40  // offset

`endif

// File: logic/asg_pkg.sv
//////////////////////////////
// shared types of the generator channel
// imported in module headers where needed
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

package asg_pkg;

  // signed table sample, also the DAC word
  typedef logic signed [`ASG_DW-1:0] sample_t;

  // gain, unity at 1 << ASG_GAIN_FRAC
  typedef logic signed [15:0] gain_t;

  // read pointer, integer table index over fraction
  typedef logic [`ASG_AW+`ASG_CWF-1:0] ptr_t;

  // generator state
  typedef enum logic [1:0] {
    st_idle,   // stopped
    st_armed,  // started, waiting for trigger
    st_run,    // reading the table
    st_pause   // gap between bursts
  } asg_state_e;

endpackage

`default_nettype wire

// File: logic/asg_regs.sv
//////////////////////////////
// CPU register bank of the channel
// holds configuration and event masks, decodes start/stop/trigger
// strobes and keeps interrupt status
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_regs import asg_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  // register port
  input  logic                reg_wen,
  input  logic                reg_ren,
  input  logic [`ASG_BAW-1:0] reg_addr,
  input  logic [31:0]         reg_wdata,
  output logic [31:0]         reg_rdata,
  output logic                reg_ack,
  // events and core status
  input  logic [`ASG_EW-1:0]  evn_ext,
  input  logic                sts_run,
  input  logic [31:0]         sts_bln,
  input  logic [15:0]         sts_bnm,
  // control pulses
  output logic                sw_rst,
  output logic                ctl_str,
  output logic                ctl_stp,
  output logic                ctl_trg,
  // configuration
  output ptr_t                cfg_siz,
  output ptr_t                cfg_off,
  output ptr_t                cfg_ste,
  output logic                cfg_ben,
  output logic                cfg_inf,
  output logic [`ASG_AW-1:0]  cfg_bdl,
  output logic [31:0]         cfg_bln,
  output logic [15:0]         cfg_bnm,
  output gain_t               cfg_mul,
  output sample_t             cfg_sum,
  output logic                irq
);

  logic [`ASG_EW-1:0] msk_str;  // event masks
  logic [`ASG_EW-1:0] msk_stp;
  logic [`ASG_EW-1:0] msk_trg;
  logic [2:0]         ien;
  logic [2:0]         ist;
  logic               ctl_wr;   // software write to CTL
  logic [2:0]         ist_clr;

  assign ctl_wr  = reg_wen && (reg_addr == `ASG_R_CTL);
  assign ist_clr = (reg_wen && (reg_addr == `ASG_R_IST)) ? reg_wdata[2:0] : 3'b000;

  //////////////////////////////
  // configuration writes
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
      ien     <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_ste <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= '0;
      cfg_sum <= '0;
    end else if (reg_wen) begin
      case (reg_addr)
        `ASG_R_STR: msk_str <= reg_wdata[`ASG_EW-1:0];
        `ASG_R_STP: msk_stp <= reg_wdata[`ASG_EW-1:0];
        `ASG_R_TRG: msk_trg <= reg_wdata[`ASG_EW-1:0];
        `ASG_R_IEN: ien     <= reg_wdata[2:0];
        `ASG_R_SIZ: cfg_siz <= reg_wdata[$bits(ptr_t)-1:0];
        `ASG_R_OFF: cfg_off <= reg_wdata[$bits(ptr_t)-1:0];
        `ASG_R_STE: cfg_ste <= reg_wdata[$bits(ptr_t)-1:0];
        `ASG_R_BCF: begin
          cfg_ben <= reg_wdata[0];
          cfg_inf <= reg_wdata[1];
        end
        `ASG_R_BDL: cfg_bdl <= reg_wdata[`ASG_AW-1:0];
        `ASG_R_BLN: cfg_bln <= reg_wdata;
        `ASG_R_BNM: cfg_bnm <= reg_wdata[15:0];
        `ASG_R_MUL: cfg_mul <= reg_wdata[15:0];
        `ASG_R_SUM: cfg_sum <= reg_wdata[`ASG_DW-1:0];
        default: ;  // read only or unmapped
      endcase
    end
  end

  //////////////////////////////
  // control pulses and interrupts
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sw_rst  <= 1'b0;
      ctl_str <= 1'b0;
      ctl_stp <= 1'b0;
      ctl_trg <= 1'b0;
      ist     <= '0;
      irq     <= 1'b0;
      reg_ack <= 1'b0;
    end else begin
      sw_rst  <= ctl_wr && reg_wdata[0];
      ctl_str <= (ctl_wr && reg_wdata[1]) || |(evn_ext & msk_str);  // sw or masked event
      ctl_stp <= (ctl_wr && reg_wdata[2]) || |(evn_ext & msk_stp);
      ctl_trg <= (ctl_wr && reg_wdata[3]) || |(evn_ext & msk_trg);
      if (sw_rst) begin
        ist <= '0;
      end else begin
        ist <= (ist & ~ist_clr) | {ctl_trg, ctl_stp, ctl_str};  // new events win over clear
      end
      irq     <= |(ist & ien);
      reg_ack <= reg_wen || reg_ren;
    end
  end

  // read data valid with reg_ack
  always_ff @(posedge bus) begin
    case (reg_addr)
      `ASG_R_CTL: reg_rdata <= {31'd0, sts_run};
      `ASG_R_STR: reg_rdata <= 32'(msk_str);
      `ASG_R_STP: reg_rdata <= 32'(msk_stp);
      `ASG_R_TRG: reg_rdata <= 32'(msk_trg);
      `ASG_R_IEN: reg_rdata <= {29'd0, ien};
      `ASG_R_IST: reg_rdata <= {29'd0, ist};
      `ASG_R_SIZ: reg_rdata <= 32'(cfg_siz);
      `ASG_R_OFF: reg_rdata <= 32'(cfg_off);
      `ASG_R_STE: reg_rdata <= 32'(cfg_ste);
      `ASG_R_BCF: reg_rdata <= {30'd0, cfg_inf, cfg_ben};
      `ASG_R_BDL: reg_rdata <= 32'(cfg_bdl);
      `ASG_R_BLN: reg_rdata <= cfg_bln;
      `ASG_R_BNM: reg_rdata <= {16'd0, cfg_bnm};
      `ASG_R_SBL: reg_rdata <= sts_bln;
      `ASG_R_SBN: reg_rdata <= {16'd0, sts_bnm};
      `ASG_R_MUL: reg_rdata <= {16'd0, cfg_mul};  // raw bits without sign extension
      `ASG_R_SUM: reg_rdata <= {{(32-`ASG_DW){1'b0}}, cfg_sum};
      default:    reg_rdata <= '0;
    endcase
  end

  // one access is either a write or a read
  a_one_access: assert property (@(posedge bus) disable iff (ctl_rst)
    !(reg_wen && reg_ren));

endmodule

`default_nettype wire

// File: logic/asg_tbl_arb.sv
//////////////////////////////
// table RAM arbiter with the CPU table port ahead of the generator
// tracks the owner of each read and steers the data back
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_tbl_arb import asg_pkg::*; (
  input  logic               bus,
  input  logic               ctl_rst,
  // CPU table port
  input  logic               tbl_wen,
  input  logic               tbl_ren,
  input  logic [`ASG_AW-1:0] tbl_addr,
  input  sample_t            tbl_wdata,
  output sample_t            tbl_rdata,
  output logic               tbl_ack,
  // generator read port
  input  logic               gen_req,
  input  logic [`ASG_AW-1:0] gen_addr,
  output logic               gen_gnt,
  output logic               gen_vld,
  output sample_t            gen_dat,
  // RAM side
  output logic               ram_en,
  output logic               ram_we,
  output logic [`ASG_AW-1:0] ram_addr,
  output sample_t            ram_wdata,
  input  sample_t            ram_rdata
);

  logic cpu_acc;

  assign cpu_acc = tbl_wen || tbl_ren;
  assign gen_gnt = gen_req && !cpu_acc;  // generator only on a free cycle

  assign ram_en    = cpu_acc || gen_req;
  assign ram_we    = tbl_wen;
  assign ram_addr  = cpu_acc ? tbl_addr : gen_addr;
  assign ram_wdata = tbl_wdata;

  // read owner one cycle behind the RAM access
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      tbl_ack <= 1'b0;
      gen_vld <= 1'b0;
    end else begin
      tbl_ack <= cpu_acc;   // writes are acked too
      gen_vld <= gen_gnt;
    end
  end

  assign tbl_rdata = ram_rdata;  // meaningful with tbl_ack
  assign gen_dat   = ram_rdata;  // meaningful with gen_vld

  // a denied generator read repeats at the same address
  a_stall_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    gen_req && !gen_gnt |=> !gen_req || $stable(gen_addr));

endmodule

`default_nettype wire

// File: logic/asg_tbl_ram.sv
//////////////////////////////
// single port waveform table
// registered read, a write leaves the read output alone
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_tbl_ram import asg_pkg::*; (
  input  logic               bus,
  input  logic               ram_en,
  input  logic               ram_we,
  input  logic [`ASG_AW-1:0] ram_addr,
  input  sample_t            ram_wdata,
  output sample_t            ram_rdata
);

  sample_t mem [2**`ASG_AW];

  always_ff @(posedge bus) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end else begin
        ram_rdata <= mem[ram_addr];  // data next cycle
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/asg_core.sv
//////////////////////////////
// generator core, fixed point read pointer and burst FSM
// issues one table read request per cycle in run state,
// the pointer only moves on a grant
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_core import asg_pkg::*; (
  input  logic               bus,
  input  logic               ctl_rst,
  input  logic               sw_rst,
  input  logic               ctl_str,
  input  logic               ctl_stp,
  input  logic               ctl_trg,
  // configuration
  input  ptr_t               cfg_siz,
  input  ptr_t               cfg_off,
  input  ptr_t               cfg_ste,
  input  logic               cfg_ben,
  input  logic               cfg_inf,
  input  logic [`ASG_AW-1:0] cfg_bdl,
  input  logic [31:0]        cfg_bln,
  input  logic [15:0]        cfg_bnm,
  // table read request
  output logic               gen_req,
  output logic [`ASG_AW-1:0] gen_addr,
  input  logic               gen_gnt,
  // status and events
  output logic               sts_run,
  output logic [31:0]        sts_bln,
  output logic [15:0]        sts_bnm,
  output logic               evn_per,
  output logic               evn_lst
);

  asg_state_e            state;
  ptr_t                  ptr;
  logic [$bits(ptr_t):0] ptr_sum;  // extra carry bit
  logic                  wrap;
  logic [31:0]           bln_nxt;
  logic [15:0]           bnm_nxt;
  logic                  bst_end;  // last grant of a burst
  logic                  pau_end;  // last pause cycle

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_ste};
  assign wrap    = ptr_sum >= {1'b0, cfg_siz};
  assign bln_nxt = sts_bln + 32'd1;
  assign bnm_nxt = sts_bnm + 16'd1;
  assign bst_end = cfg_ben && (bln_nxt >= 32'(cfg_bdl));
  assign pau_end = bln_nxt >= cfg_bln;

  assign gen_req  = (state == st_run);
  assign gen_addr = ptr[`ASG_CWF +: `ASG_AW];  // integer part
  assign sts_run  = (state == st_run) || (state == st_pause);

  //////////////////////////////
  // state, pointer, counters
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      state   <= st_idle;
      ptr     <= '0;
      sts_bln <= '0;
      sts_bnm <= '0;
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
    end else begin
      evn_per <= 1'b0;
      evn_lst <= 1'b0;
      if (ctl_stp) begin
        state <= st_idle;  // stop from anywhere
      end else begin
        case (state)
          st_idle: if (ctl_str) state <= st_armed;
          st_armed: begin
            if (ctl_trg) begin
              state   <= st_run;
              ptr     <= cfg_off;  // phase
              sts_bln <= '0;
              sts_bnm <= '0;
            end
          end
          st_run: begin
            if (gen_gnt) begin
              // step, fold back at the table size
              ptr     <= wrap ? ptr_t'(ptr_sum - {1'b0, cfg_siz}) : ptr_t'(ptr_sum);
              evn_per <= wrap;
              if (cfg_ben) sts_bln <= bln_nxt;  // counts grants in a burst
              if (bst_end) begin
                sts_bln <= '0;
                sts_bnm <= bnm_nxt;
                if (!cfg_inf && (bnm_nxt >= cfg_bnm)) begin
                  state   <= st_idle;  // last burst done
                  evn_lst <= 1'b1;
                end else begin
                  state <= st_pause;
                end
              end
            end
          end
          st_pause: begin
            // counts idle cycles, resume from current pointer
            if (pau_end) begin
              state   <= st_run;
              sts_bln <= '0;
            end else begin
              sts_bln <= bln_nxt;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // requested entry stays inside the programmed table
  a_addr_range: assert property (@(posedge bus) disable iff (ctl_rst)
    gen_req |-> ({gen_addr, {`ASG_CWF{1'b0}}} < cfg_siz));

endmodule

`default_nettype wire

// File: logic/asg_lin.sv
//////////////////////////////
// gain and offset stage in front of the DAC
// one registered result per valid table read
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_lin import asg_pkg::*; (
  input  logic    bus,
  input  logic    ctl_rst,
  input  logic    gen_vld,
  input  sample_t gen_dat,
  input  gain_t   cfg_mul,
  input  sample_t cfg_sum,
  output sample_t dac_dat,
  output logic    dac_vld
);

  localparam int sat_max = 2**(`ASG_DW-1) - 1;
  localparam int sat_min = -(2**(`ASG_DW-1));

  logic signed [`ASG_DW+15:0] prod;  // full product
  logic signed [`ASG_DW+16:0] acc;   // after shift and offset, one guard bit
  sample_t                    dat_sat;

  assign prod = gen_dat * cfg_mul;
  assign acc  = (prod >>> `ASG_GAIN_FRAC) + cfg_sum;

  // clip to the sample range
  always_comb begin
    if (acc > sat_max) begin
      dat_sat = sample_t'(sat_max);
    end else if (acc < sat_min) begin
      dat_sat = sample_t'(sat_min);
    end else begin
      dat_sat = sample_t'(acc);
    end
  end

  always_ff @(posedge bus) begin
    if (gen_vld) dac_dat <= dat_sat;  // held between samples
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      dac_vld <= 1'b0;
    end else begin
      dac_vld <= gen_vld;
    end
  end

endmodule

`default_nettype wire

// File: logic/asg_top.sv
//////////////////////////////
// one channel of the waveform generator
// register bank, table arbiter and RAM, core and gain stage
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_top import asg_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  // CPU register port
  input  logic                reg_wen,
  input  logic                reg_ren,
  input  logic [`ASG_BAW-1:0] reg_addr,
  input  logic [31:0]         reg_wdata,
  output logic [31:0]         reg_rdata,
  output logic                reg_ack,
  // CPU table port
  input  logic                tbl_wen,
  input  logic                tbl_ren,
  input  logic [`ASG_AW-1:0]  tbl_addr,
  input  sample_t             tbl_wdata,
  output sample_t             tbl_rdata,
  output logic                tbl_ack,
  // events, interrupt, DAC
  input  logic [`ASG_EW-1:0]  evn_ext,
  output logic                evn_per,
  output logic                evn_lst,
  output logic                irq,
  output sample_t             dac_dat,
  output logic                dac_vld
);

  //////////////////////////////
  // internal wires
  //////////////////////////////
  logic               sw_rst;
  logic               ctl_str;
  logic               ctl_stp;
  logic               ctl_trg;
  ptr_t               cfg_siz;
  ptr_t               cfg_off;
  ptr_t               cfg_ste;
  logic               cfg_ben;
  logic               cfg_inf;
  logic [`ASG_AW-1:0] cfg_bdl;
  logic [31:0]        cfg_bln;
  logic [15:0]        cfg_bnm;
  gain_t              cfg_mul;
  sample_t            cfg_sum;
  logic               sts_run;
  logic [31:0]        sts_bln;
  logic [15:0]        sts_bnm;
  // generator read path
  logic               gen_req;
  logic [`ASG_AW-1:0] gen_addr;
  logic               gen_gnt;
  logic               gen_vld;
  sample_t            gen_dat;
  // RAM port
  logic               ram_en;
  logic               ram_we;
  logic [`ASG_AW-1:0] ram_addr;
  sample_t            ram_wdata;
  sample_t            ram_rdata;

  // all ports connect by matching names
  asg_regs u_regs (.*);

  asg_tbl_arb u_arb (.*);

  asg_tbl_ram u_ram (.*);

  asg_core u_core (.*);

  asg_lin u_lin (.*);

endmodule

`default_nettype wire

// File: verif/asg_tests.svh
//////////////////////////////
// directed tests of the generator channel
// included inside the testbench top, uses its tasks and model
//////////////////////////////
`ifndef ASG_TESTS_SVH
`define ASG_TESTS_SVH

task automatic flush_stream();
  dac_q.delete();
  per_q.delete();
  per_d   = 1'b0;
  lst_cnt = 0;
endtask

task automatic set_ptr(input logic [31:0] siz, input logic [31:0] off, input logic [31:0] ste);
  reg_write(`ASG_R_SIZ, siz);
  reg_write(`ASG_R_OFF, off);
  reg_write(`ASG_R_STE, ste);
  m_siz = longint'(siz);
  m_off = longint'(off);
  m_ste = longint'(ste);
endtask

task automatic start_trigger();
  reg_write(`ASG_R_CTL, 32'h2);  // start
  reg_write(`ASG_R_CTL, 32'h8);  // trigger
endtask

task automatic stop_drain();
  reg_write(`ASG_R_CTL, 32'h4);
  wait_cycles(4);  // samples in flight
endtask

task automatic wait_samples(input int n);
  int k;
  k = 0;
  while (dac_q.size() < n && k < 4 * n + 40) begin
    wait_cycles(1);
    k++;
  end
  if (dac_q.size() < n) note_failure($sformatf("only %0d of %0d DAC samples", dac_q.size(), n));
endtask

// writes, readback masks, unmapped reads, table fill and readback
task automatic test_regs_table();
  logic [`ASG_BAW-1:0] ra [13] = '{`ASG_R_STR, `ASG_R_STP, `ASG_R_TRG, `ASG_R_IEN,
    `ASG_R_SIZ, `ASG_R_OFF, `ASG_R_STE, `ASG_R_BCF, `ASG_R_BDL, `ASG_R_BLN,
    `ASG_R_BNM, `ASG_R_MUL, `ASG_R_SUM};
  logic [31:0] rm [13] = '{32'h1f, 32'h1f, 32'h1f, 32'h7, 32'h3ff_ffff, 32'h3ff_ffff,
    32'h3ff_ffff, 32'h3, 32'h3ff, 32'hffff_ffff, 32'hffff, 32'hffff, 32'h3fff};
  logic [`ASG_BAW-1:0] um [4] = '{7'h44, 7'h48, 7'h4c, 7'h7c};
  logic [31:0] wv;
  logic [31:0] rd;
  sample_t     td;
  for (int i = 0; i < 13; i++) begin
    wv = rand_word();
    reg_write(ra[i], wv);
    reg_read(ra[i], rd);
    compare_word($sformatf("reg %h", ra[i]), rd, wv & rm[i]);  // field width
  end
  for (int i = 0; i < 13; i++) reg_write(ra[i], 32'd0);
  for (int i = 0; i < 4; i++) begin
    reg_read(um[i], rd);
    compare_word($sformatf("unmapped %h", um[i]), rd, 32'd0);
  end
  for (int i = 0; i < 2**`ASG_AW; i++) begin
    tbl_copy[i] = sample_t'(rand_word() >> 18);
    tbl_access(1'b1, `ASG_AW'(i), tbl_copy[i], td);
  end
  for (int i = 0; i < 2**`ASG_AW; i++) begin
    tbl_access(1'b0, `ASG_AW'(i), '0, td);
    compare_sample($sformatf("tbl_rdata[%0d]", i), td, tbl_copy[i]);
  end
endtask

// 100 entries, phase 3.25, step 2.375
task automatic test_playback();
  set_ptr(32'h64_0000, 32'h3_4000, 32'h2_6000);
  reg_write(`ASG_R_MUL, 32'h2000);  // unity
  reg_write(`ASG_R_SUM, 32'h0);
  flush_stream();
  start_trigger();
  wait_samples(120);
  compare_word("trigger to dac_vld cycles", first_dac_cyc - acc_cyc, 32'd4);
  stop_drain();
  build_model(120, 16'sh2000, '0);
  check_stream(120, 1'b0);
endtask

task automatic test_gain();
  gain_t   g;
  sample_t o;
  for (int r = 0; r < 6; r++) begin
    if (r == 0) begin
      g = 16'sh7fff;  // about 4x, clips high
      o = 14'sh1fff;
    end else if (r == 1) begin
      g = 16'sh8000;  // -4x, clips both ways
      o = 14'sh2000;
    end else begin
      g = gain_t'(rand_word() >> 16);
      o = sample_t'(rand_word() >> 18);
    end
    reg_write(`ASG_R_MUL, 32'(g) & 32'hffff);
    reg_write(`ASG_R_SUM, 32'(o) & 32'h3fff);
    flush_stream();
    start_trigger();
    wait_samples(24);
    stop_drain();
    build_model(24, g, o);
    check_stream(24, 1'b0);
  end
endtask

// 4 bursts of 5, then the infinite case
task automatic test_burst();
  logic [31:0] rd;
  int          k;
  set_ptr(32'h40_0000, 32'h0, 32'h1_8000);
  reg_write(`ASG_R_MUL, 32'h2000);
  reg_write(`ASG_R_SUM, 32'h0);
  reg_write(`ASG_R_BDL, 32'd5);
  reg_write(`ASG_R_BLN, 32'd3);
  reg_write(`ASG_R_BNM, 32'd4);
  reg_write(`ASG_R_BCF, 32'h1);
  flush_stream();
  start_trigger();
  k = 0;
  while (lst_cnt == 0 && k < 200) begin
    wait_cycles(1);
    k++;
  end
  if (lst_cnt == 0) note_failure("evn_lst never pulsed in finite burst mode");
  wait_cycles(6);
  build_model(20, 16'sh2000, '0);
  check_stream(20, 1'b1);
  compare_word("evn_lst pulses", lst_cnt, 32'd1);
  reg_read(`ASG_R_CTL, rd);
  compare_word("sts_run after last burst", rd, 32'd0);
  reg_write(`ASG_R_BCF, 32'h3);  // infinite
  flush_stream();
  start_trigger();
  wait_samples(40);
  reg_read(`ASG_R_CTL, rd);
  compare_word("sts_run in infinite burst", rd, 32'd1);
  stop_drain();
  reg_read(`ASG_R_CTL, rd);
  compare_word("sts_run after stop", rd, 32'd0);
  build_model(40, 16'sh2000, '0);
  check_stream(40, 1'b0);
  reg_write(`ASG_R_BCF, 32'h0);
endtask

// CPU reads steal RAM cycles while the core plays
task automatic test_arbitration();
  logic [`ASG_AW-1:0] a;
  sample_t            td;
  set_ptr(32'hc8_0000, 32'h11_8000, 32'h0_c000);
  flush_stream();
  start_trigger();
  for (int i = 0; i < 40; i++) begin
    a = `ASG_AW'(rand_word() >> 12);
    tbl_access(1'b0, a, '0, td);
    compare_sample($sformatf("tbl_rdata at %h", a), td, tbl_copy[a]);
    wait_cycles(int'(rand_word() >> 30) + 1);
  end
  wait_samples(60);
  stop_drain();
  build_model(60, 16'sh2000, '0);
  check_stream(60, 1'b0);
endtask

task automatic test_events();
  logic [31:0] rd;
  reg_write(`ASG_R_IST, 32'h7);  // drop old status
  reg_write(`ASG_R_STR, 32'h04);
  reg_write(`ASG_R_TRG, 32'h10);
  reg_write(`ASG_R_IEN, 32'h5);
  flush_stream();
  evn_ext = 5'h04;  // start event
  wait_cycles(1);
  evn_ext = 5'h00;
  wait_cycles(2);
  evn_ext = 5'h10;  // trigger event
  wait_cycles(1);
  evn_ext = 5'h00;
  wait_samples(8);
  reg_read(`ASG_R_IST, rd);
  compare_word("IST after events", rd, 32'h5);
  reg_read(`ASG_R_CTL, rd);
  compare_word("sts_run after events", rd, 32'd1);
  compare_bit("irq enabled", irq, 1'b1);
  reg_write(`ASG_R_IEN, 32'h0);
  wait_cycles(2);
  compare_bit("irq masked", irq, 1'b0);
  reg_write(`ASG_R_IEN, 32'h5);
  wait_cycles(2);
  compare_bit("irq unmasked", irq, 1'b1);
  reg_write(`ASG_R_IST, 32'h7);
  wait_cycles(2);
  compare_bit("irq after clear", irq, 1'b0);
  reg_read(`ASG_R_IST, rd);
  compare_word("IST after clear", rd, 32'h0);
  stop_drain();
  build_model(8, 16'sh2000, '0);
  check_stream(8, 1'b0);
  reg_write(`ASG_R_STR, 32'h0);
  reg_write(`ASG_R_TRG, 32'h0);
  reg_write(`ASG_R_IEN, 32'h0);
endtask

`endif

// File: verif/asg_tb.sv
//////////////////////////////
// testbench top for one generator channel
// clock, reset, watchdog, bus tasks, DAC monitor and reference model
// directed tests come from the included test file
//////////////////////////////
`default_nettype none
`include "asg_config.svh"

module asg_tb import asg_pkg::*; ();

  // cycle budgets per test, watchdog derives from their sum
  localparam int budget_cycles = 2600 + 400 + 600 + 500 + 500 + 300 + 20;

  logic               bus = 1'b0;
  logic               ctl_rst;
  logic               reg_wen;
  logic               reg_ren;
  logic [`ASG_BAW-1:0] reg_addr;
  logic [31:0]        reg_wdata;
  logic [31:0]        reg_rdata;
  logic               reg_ack;
  logic               tbl_wen;
  logic               tbl_ren;
  logic [`ASG_AW-1:0] tbl_addr;
  sample_t            tbl_wdata;
  sample_t            tbl_rdata;
  logic               tbl_ack;
  logic [`ASG_EW-1:0] evn_ext;
  logic               evn_per;
  logic               evn_lst;
  logic               irq;
  sample_t            dac_dat;
  logic               dac_vld;

  int          n_checks;
  int          n_errors;
  int          err_base;      // errors before the current test
  int          cyc;           // edge counter
  int          acc_cyc;       // cycle in which the last register access was driven
  int          first_dac_cyc;
  int          lst_cnt;
  logic [31:0] lcg_state;
  sample_t     tbl_copy [2**`ASG_AW];  // model copy of the table
  sample_t     dac_q [$];     // DAC samples as seen
  bit          per_q [$];     // evn_per flag per sample
  bit          per_d;
  sample_t     exp_q [$];     // model samples
  bit          exp_per [$];
  longint      m_siz;         // model pointer config
  longint      m_off;
  longint      m_ste;

  asg_top dut0 (.*);

  always #20 bus = ~bus;

  always @(posedge bus) cyc <= cyc + 1;

  // DAC monitor, samples settled outputs
  always @(posedge bus) begin
    #5;
    if (dac_vld) begin
      if (dac_q.size() == 0) first_dac_cyc = cyc;
      dac_q.push_back(dac_dat);
      per_q.push_back(per_d);  // evn_per leads its sample by one cycle
    end
    per_d = evn_per;
    if (evn_lst) lst_cnt++;
  end

  // watchdog
  initial begin
    #(longint'(budget_cycles) * 40 + 4000);
    $display("timeout, the tests did not finish within the cycle budget");
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////
  // helpers and checks
  //////////////////////////////
  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic note_failure(input string msg);
    $display("%s", msg);
    n_checks++;
    n_errors++;
  endtask

  task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge bus);
      #5;
    end
  endtask

  // one register access, called 5 units after an edge
  task automatic reg_access(input bit wr, input logic [`ASG_BAW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    reg_wen   = wr;
    reg_ren   = !wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    acc_cyc   = cyc;
    do begin
      @(posedge bus);
      #5;
      n++;
      reg_wen = 1'b0;
      reg_ren = 1'b0;
    end while (!reg_ack && n < 8);
    rdata = reg_rdata;  // valid while ack is high
    if (!reg_ack) note_failure($sformatf("register access at %h got no ack", addr));
    else if (n != 1) note_failure($sformatf("register ack at %h came late", addr));
  endtask

  task automatic reg_write(input logic [`ASG_BAW-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input logic [`ASG_BAW-1:0] addr, output logic [31:0] rdata);
    reg_access(1'b0, addr, 32'd0, rdata);
  endtask

  task automatic tbl_access(input bit wr, input logic [`ASG_AW-1:0] addr,
                            input sample_t wdata, output sample_t rdata);
    int n;
    n = 0;
    tbl_wen   = wr;
    tbl_ren   = !wr;
    tbl_addr  = addr;
    tbl_wdata = wdata;
    do begin
      @(posedge bus);
      #5;
      n++;
      tbl_wen = 1'b0;
      tbl_ren = 1'b0;
    end while (!tbl_ack && n < 8);
    rdata = tbl_rdata;
    if (!tbl_ack) note_failure($sformatf("table access at %h got no ack", addr));
    else if (n != 1) note_failure($sformatf("table ack at %h came late", addr));
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic sample_t gain_ref(input sample_t s, input gain_t g, input sample_t o);
    longint p;
    longint hi;
    hi = (longint'(1) <<< (`ASG_DW - 1)) - 1;
    p  = (longint'(s) * longint'(g)) >>> `ASG_GAIN_FRAC;
    p  = p + longint'(o);
    if (p > hi) p = hi;             // clip high
    else if (p < -hi - 1) p = -hi - 1;
    return sample_t'(p);
  endfunction

  // expected samples and wrap flags from the pointer rule
  task automatic build_model(input int n, input gain_t g, input sample_t o);
    longint             p;
    longint             sum;
    logic [`ASG_AW-1:0] a;
    exp_q.delete();
    exp_per.delete();
    p = m_off;
    repeat (n) begin
      a = `ASG_AW'(p >> `ASG_CWF);  // integer part
      exp_q.push_back(gain_ref(tbl_copy[a], g, o));
      sum = p + m_ste;
      if (sum >= m_siz) begin
        p = sum - m_siz;
        exp_per.push_back(1'b1);
      end else begin
        p = sum;
        exp_per.push_back(1'b0);
      end
    end
  endtask

  task automatic check_stream(input int n, input bit exact);
    int per_got;
    int per_exp;
    per_got = 0;
    per_exp = 0;
    if (exact) compare_word("dac sample count", dac_q.size(), n);
    else if (dac_q.size() < n) note_failure("fewer DAC samples than expected");
    for (int i = 0; i < n && i < dac_q.size(); i++) begin
      compare_sample($sformatf("dac_dat[%0d]", i), dac_q[i], exp_q[i]);
      per_got += int'(per_q[i]);
      per_exp += int'(exp_per[i]);
    end
    compare_word("evn_per count", per_got, per_exp);
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d errors", name, n_errors - err_base);
    err_base = n_errors;
  endtask

  `include "asg_tests.svh"

  initial begin
    ctl_rst   = 1'b1;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    tbl_wen   = 1'b0;
    tbl_ren   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    evn_ext   = '0;
    cyc       = 0;
    n_checks  = 0;
    n_errors  = 0;
    err_base  = 0;
    lst_cnt   = 0;
    per_d     = 1'b0;
    lcg_state = 32'hb512;
    repeat (8) @(posedge bus);
    #5;
    ctl_rst = 1'b0;
    test_regs_table();
    report_test("register and table access");
    test_playback();
    report_test("continuous playback");
    test_gain();
    report_test("gain, offset and saturation");
    test_burst();
    report_test("burst mode");
    test_arbitration();
    report_test("arbitration under traffic");
    test_events();
    report_test("events and interrupts");
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: asg.f
+incdir+logic
+incdir+verif
logic/asg_pkg.sv
logic/asg_regs.sv
logic/asg_tbl_arb.sv
logic/asg_tbl_ram.sv
logic/asg_core.sv
logic/asg_lin.sv
logic/asg_top.sv
verif/asg_tb.sv

// File: Makefile
# Verilator build and run of the waveform generator testbench

TOOL  := verilator
FLAGS := --binary --assert -Wno-fatal -j 0
TOP   := asg_tb
FLIST := asg.f
OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(filter %.sv,$(shell cat $(FLIST))) $(wildcard logic/*.svh verif/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "Checks failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "FAIL, no result"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ) $(LOG)
